// File: files.f
+incdir+.
cnt_types_pkg.sv
cnt_msg_pkg.sv
cnt_load_intake.sv
cnt_segment.sv
cnt_segmented_counter.sv
cnt_expiry_out.sv
cnt_timer_top.sv
cnt_timer_asserts.sv
tb_cnt_timer.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := tb_cnt_timer
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_cnt_timer.sv
// Testbench for the segmented down-count timer
// Table rows run one at a time, then a tick pause and output back-pressure
`timescale 1ns/1ps
`default_nettype none

`include "cnt_macros.svh"

module tb_cnt_timer;

    import cnt_types_pkg::*;
    import cnt_msg_pkg::*;

    typedef struct packed {
        count_t     start;
        tag_t       tag;
        logic [7:0] duty;  // Tick probability in percent
    } row_t;

    localparam int n_rows     = 10;
    localparam int wait_limit = 200000;  // Covers 0xFFFF at full duty
    // Two sent, one in the holding register, one in the counter, a full queue
    localparam int n_burst    = `CNT_CMD_DEPTH + `CNT_EVT_CREDITS_INIT + 2;

    // Start value, tag, tick duty
    localparam row_t stim_table [n_rows] = '{
        '{16'h0000, 4'h1, 8'd100},
        '{16'h0001, 4'h2, 8'd60},
        '{16'h000f, 4'h3, 8'd70},
        '{16'h0010, 4'h4, 8'd50},  // Borrow into segment 1
        '{16'h0011, 4'h5, 8'd80},
        '{16'h0100, 4'h6, 8'd40},  // Borrow into segment 2
        '{16'h1000, 4'h7, 8'd90},  // Borrow into segment 3
        '{16'h0123, 4'h8, 8'd30},
        '{16'hffff, 4'h9, 8'd100}, // Full range
        '{16'h0007, 4'ha, 8'd25}
    };

    logic        clk = 1'b0;
    logic        rst_n;
    logic        tick = 1'b0;
    logic        tick_high;
    logic        cmd_valid;
    load_cmd_t   cmd;
    logic        evt_credit = 1'b0;
    logic        credit_now;
    logic        cmd_credit;
    logic        evt_valid;
    expiry_evt_t evt;
    logic        done;

    expiry_evt_t exp_q [$];  // Sent commands, oldest first
    expiry_evt_t rx_q [$];   // Events seen downstream
    int          tick_duty    = 0;
    int          hold_credits = 0;  // Nonzero withholds downstream credits
    int          cmds_sent    = 0;
    int          credits_back = 0;
    int          credits_owed = 0;
    int          gap_cnt      = 0;
    int          n_checked    = 0;
    int          error_count  = 0;
    int          waited;
    int          ticks_given;
    int          base;

    cnt_timer_top i_cnt_timer_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .evt_credit (evt_credit),
        .cmd_credit (cmd_credit),
        .evt_valid  (evt_valid),
        .evt        (evt),
        .done       (done)
    );

    always #4 clk = ~clk;  // 8 ns period

    // Tick drawn at the edge, driven just after it
    always @(posedge clk) begin
        tick_high = ($urandom % 100) < tick_duty;
        #1;
        tick = tick_high;
    end

    // Upstream credit returns
    always @(posedge clk) begin
        if (rst_n && cmd_credit) begin
            credits_back++;
        end
    end

    // Downstream side: collects events, returns credits after random gaps
    always @(posedge clk) begin
        credit_now = 1'b0;
        if (rst_n && evt_valid) begin
            rx_q.push_back(evt);
            credits_owed++;
        end
        if (credits_owed > 0 && hold_credits == 0) begin
            if (gap_cnt == 0) begin
                credit_now = 1'b1;
                credits_owed--;
            end else begin
                gap_cnt--;
            end
        end
        #1;
        evt_credit = credit_now;
        if (credit_now) begin
            gap_cnt = $urandom % 4;
        end
    end

    function automatic int upstream_credits();
        return `CNT_CMD_DEPTH - cmds_sent + credits_back;
    endfunction

    task automatic check_eq(input string what, input int got, input int expected);
        if (got !== expected) begin
            error_count++;
            $display("ERR %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("Run stopped: %s", why);
        $display("TEST FAILED");
        $fatal(1, "testbench aborted");
    endtask

    // Each new event against the oldest outstanding command
    task automatic compare_events();
        expiry_evt_t head;
        while (n_checked < rx_q.size()) begin
            if (exp_q.size() == 0) begin
                abort_run("an event arrived with no command outstanding");
            end else begin
                head = exp_q.pop_front();
                check_eq("event tag", int'(rx_q[n_checked].tag), int'(head.tag));
                check_eq("event start", int'(rx_q[n_checked].start), int'(head.start));
                n_checked++;
            end
        end
    endtask

    // Called and returns 1 ns after an edge
    task automatic send_cmd(input count_t start, input tag_t tag);
        expiry_evt_t next_evt;
        int          cycles;
        cycles = 0;
        while (upstream_credits() == 0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > wait_limit) begin
                abort_run("upstream never got a command credit back");
            end
        end
        cmd_valid     = 1'b1;
        cmd.tag       = tag;
        cmd.start     = start;
        next_evt.tag  = tag;
        next_evt.start = start;
        exp_q.push_back(next_evt);
        cmds_sent++;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    // Returns on the edge that samples the credit pulse of the load
    task automatic wait_load();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!cmd_credit) begin
            cycles++;
            if (cycles > wait_limit) begin
                abort_run("the counter never loaded the command");
            end
            @(posedge clk);
        end
    endtask

    task automatic wait_events(input int target);
        int cycles;
        cycles = 0;
        while (rx_q.size() < target) begin
            @(posedge clk);
            #1;
            compare_events();
            cycles++;
            if (cycles > wait_limit) begin
                abort_run("expiry events stopped arriving");
            end
        end
        compare_events();
    endtask

    initial begin
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        void'($urandom(64));
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Quiet after reset
        repeat (10) begin
            @(posedge clk);
            check_eq("evt_valid after reset", int'(evt_valid), 0);
            check_eq("cmd_credit after reset", int'(cmd_credit), 0);
            check_eq("done after reset", int'(done), 0);
        end
        #1;

        // One row at a time, ticks counted from the load
        for (int r = 0; r < n_rows; r++) begin
            tick_duty = int'(stim_table[r].duty);
            send_cmd(stim_table[r].start, stim_table[r].tag);
            wait_load();
            ticks_given = 0;
            waited = 0;
            @(posedge clk);
            while (!done) begin
                if (tick) begin
                    ticks_given++;
                end
                waited++;
                if (waited > wait_limit) begin
                    abort_run("done never rose while ticking");
                end
                @(posedge clk);
            end
            #1;
            check_eq("ticks before done", ticks_given, int'(stim_table[r].start));
            wait_events(cmds_sent);
        end

        // Tick pause holds a loaded count
        tick_duty = 0;
        send_cmd(16'h0020, 4'hb);
        wait_load();
        #1;
        repeat (50) begin
            @(posedge clk);
            check_eq("evt_valid while paused", int'(evt_valid), 0);
            check_eq("done while paused", int'(done), 0);
        end
        #1;
        tick_duty = 100;
        wait_events(cmds_sent);

        // Let downstream credits settle back to the reset value
        waited = 0;
        while (credits_owed != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > wait_limit) begin
                abort_run("downstream credits were never returned");
            end
        end
        repeat (2) @(posedge clk);
        #1;

        // Burst with downstream credits withheld
        hold_credits = 1;
        base = rx_q.size();
        for (int i = 0; i < n_burst; i++) begin
            send_cmd(count_t'(i * 2), tag_t'(i + 3));
        end
        repeat (60) @(posedge clk);
        #1;
        compare_events();
        check_eq("events with credits withheld", rx_q.size() - base, `CNT_EVT_CREDITS_INIT);
        hold_credits = 0;
        wait_events(cmds_sent);

        check_eq("command credit pulses", credits_back, cmds_sent);

        // A stray event now finds no command to match
        repeat (20) @(posedge clk);
        #1;
        compare_events();

        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cnt_timer_asserts.sv
// Shadow model of the running count, bound into the segmented counter
// Compares the model with the segment registers and the done flag
`timescale 1ns/1ps
`default_nettype none

module cnt_timer_asserts (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   tick,
    input logic                   q_valid,
    input logic                   q_pop,
    input cnt_msg_pkg::load_cmd_t q_cmd,
    input logic                   exp_take,
    input logic                   done,
    input cnt_types_pkg::padded_t seg_count  // Segment counts, top digit first
);

    import cnt_types_pkg::*;

    count_t model_cnt;
    logic   model_held;  // Loaded and not yet handed on

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            model_cnt  <= '0;
            model_held <= 1'b0;
        end else if (q_pop) begin
            model_cnt  <= q_cmd.start;
            model_held <= 1'b1;
        end else begin
            if (tick && model_held && model_cnt != '0) begin
                model_cnt <= model_cnt - 1'b1; // One per tick, stops at zero
            end
            if (exp_take) begin
                model_held <= 1'b0;
            end
        end
    end

    a_seg_match: assert property (@(posedge clk) disable iff (!rst_n)
        seg_count == padded_t'(model_cnt))
        else $error("Segment counts differ from the model count");

    a_done_match: assert property (@(posedge clk) disable iff (!rst_n)
        done == (model_held && model_cnt == '0))
        else $error("Done does not follow the model count");

    // Pop only from a valid queue head and only with nothing held
    a_pop_valid: assert property (@(posedge clk) disable iff (!rst_n)
        q_pop |-> (q_valid && !model_held))
        else $error("Pop with an empty queue or a command still held");

endmodule

// Four segments for a 16-bit count
bind cnt_segmented_counter cnt_timer_asserts i_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .tick      (tick),
    .q_valid   (q_valid),
    .q_pop     (q_pop),
    .q_cmd     (q_cmd),
    .exp_take  (exp_take),
    .done      (done),
    .seg_count ({gen_seg[3].i_seg.count, gen_seg[2].i_seg.count,
                 gen_seg[1].i_seg.count, gen_seg[0].i_seg.count})
);

`default_nettype wire

// File: cnt_timer_top.sv
// Top of the one-channel down-count timer
// Commands in through credits, expiry events out through credits
`timescale 1ns/1ps
`default_nettype none

module cnt_timer_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     tick,       // External count strobe
    input  logic                     cmd_valid,
    input  cnt_msg_pkg::load_cmd_t   cmd,
    input  logic                     evt_credit, // From downstream
    output logic                     cmd_credit, // To upstream
    output logic                     evt_valid,
    output cnt_msg_pkg::expiry_evt_t evt,
    output logic                     done
);

    import cnt_msg_pkg::*;

    // Queue head to the counter
    logic        q_valid;
    logic        q_pop;
    load_cmd_t   q_cmd;

    // Counter to the output stage
    logic        exp_valid;
    logic        exp_take;
    expiry_evt_t exp_evt;

    cnt_load_intake i_intake (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .q_pop      (q_pop),
        .q_valid    (q_valid),
        .q_cmd      (q_cmd),
        .cmd_credit (cmd_credit)
    );

    cnt_segmented_counter i_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .tick      (tick),
        .q_valid   (q_valid),
        .q_cmd     (q_cmd),
        .exp_take  (exp_take),
        .q_pop     (q_pop),
        .exp_valid (exp_valid),
        .exp_evt   (exp_evt),
        .done      (done)
    );

    cnt_expiry_out i_expiry (
        .clk        (clk),
        .rst_n      (rst_n),
        .exp_valid  (exp_valid),
        .exp_evt    (exp_evt),
        .evt_credit (evt_credit),
        .exp_take   (exp_take),
        .evt_valid  (evt_valid),
        .evt        (evt)
    );

endmodule

`default_nettype wire

// File: cnt_expiry_out.sv
// Expiry event output stage with downstream credit flow control
// One event is held; it leaves only while a credit is available
`timescale 1ns/1ps
`default_nettype none

`include "cnt_macros.svh"

module cnt_expiry_out (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     exp_valid,  // Counter has an event
    input  cnt_msg_pkg::expiry_evt_t exp_evt,
    input  logic                     evt_credit, // Downstream returns one credit
    output logic                     exp_take,
    output logic                     evt_valid,  // One cycle per event
    output cnt_msg_pkg::expiry_evt_t evt
);

    import cnt_types_pkg::*;
    import cnt_msg_pkg::*;

    expiry_evt_t hold_evt;    // Holding register
    logic        hold_full;
    credit_t     credit_cnt;  // Downstream credits in hand
    logic        send;

    assign send = hold_full && (credit_cnt != '0);

    // Accept when empty or emptying this cycle
    assign exp_take  = exp_valid && (!hold_full || send);
    assign evt_valid = send;
    assign evt       = hold_evt;

    always_ff @(posedge clk) begin
        if (exp_take) begin
            hold_evt <= exp_evt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_full <= 1'b0;
        end else if (exp_take) begin
            hold_full <= 1'b1; // Refilled even when sending
        end else if (send) begin
            hold_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= credit_t'(`CNT_EVT_CREDITS_INIT);
        end else begin
            // Spend and return together cancel out
            case ({send, evt_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: cnt_segmented_counter.sv
// Timer core built from chained down-count segments
// Pops a command when idle, counts ticks down and holds expiry until taken
`timescale 1ns/1ps
`default_nettype none

`include "cnt_macros.svh"

module cnt_segmented_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     tick,      // External count strobe
    input  logic                     q_valid,
    input  cnt_msg_pkg::load_cmd_t   q_cmd,
    input  logic                     exp_take,  // Output side accepted event
    output logic                     q_pop,
    output logic                     exp_valid,
    output cnt_msg_pkg::expiry_evt_t exp_evt,
    output logic                     done       // Zero with a command held
);

    import cnt_types_pkg::*;
    import cnt_msg_pkg::*;

    typedef enum logic [1:0] {
        IDLE,    // Nothing held
        COUNT,   // Loaded, counting ticks
        EXPIRED  // At zero, event waiting
    } state_t;

    state_t                state;
    load_cmd_t             held_cmd;  // Tag and start of the running command
    padded_t               load_pad;
    logic [`CNT_N_SEG:0]   borrow;    // Ripple chain, bit 0 is the tick
    logic [`CNT_N_SEG-1:0] seg_zero;
    logic                  zero;
    logic                  held;
    logic                  busy;

    assign zero = &seg_zero; // Every digit at zero
    assign held = (state != IDLE);
    assign busy = (state == COUNT) && !zero;

    assign q_pop     = (state == IDLE) && q_valid;
    assign borrow[0] = tick && busy;

    // Start value spread over the digits, loaded on a pop
    assign load_pad = padded_t'(q_cmd.start);

    for (genvar i = 0; i < `CNT_N_SEG; i++) begin : gen_seg
        cnt_segment i_seg (
            .clk        (clk),
            .rst_n      (rst_n),
            .load       (q_pop),
            .load_val   (load_pad[i*`CNT_SEG_WIDTH +: `CNT_SEG_WIDTH]),
            .borrow_in  (borrow[i]),
            .count      (),
            .borrow_out (borrow[i+1]),
            .is_zero    (seg_zero[i])
        );
    end

    assign done          = held && zero;
    assign exp_valid     = done;
    assign exp_evt.tag   = held_cmd.tag;
    assign exp_evt.start = held_cmd.start;

    always_ff @(posedge clk) begin
        if (q_pop) begin
            held_cmd <= q_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (q_valid) begin
                        state <= COUNT;
                    end
                end
                COUNT: begin
                    // Taken at once if the output side is free
                    if (zero) begin
                        state <= exp_take ? IDLE : EXPIRED;
                    end
                end
                EXPIRED: begin
                    if (exp_take) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: cnt_segment.sv
// One digit of the segmented down counter
// Borrow in decrements; borrow out passes on when this digit wraps
`timescale 1ns/1ps
`default_nettype none

module cnt_segment (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load,       // Load wins over decrement
    input  cnt_types_pkg::seg_t load_val,
    input  logic                borrow_in,  // Decrement request
    output cnt_types_pkg::seg_t count,
    output logic                borrow_out, // Next digit decrements
    output logic                is_zero
);

    assign is_zero    = (count == '0);
    assign borrow_out = borrow_in && is_zero; // Wrap from 0 to max

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0; // Idle at zero
        end else if (load) begin
            count <= load_val;
        end else if (borrow_in) begin
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: cnt_load_intake.sv
// Load command queue in front of the counter
// Upstream holds one credit per free entry; each pop returns one
`timescale 1ns/1ps
`default_nettype none

`include "cnt_macros.svh"

module cnt_load_intake (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cmd_valid,  // Upstream command strobe
    input  cnt_msg_pkg::load_cmd_t cmd,
    input  logic                   q_pop,      // Counter takes the head entry
    output logic                   q_valid,    // Queue not empty
    output cnt_msg_pkg::load_cmd_t q_cmd,      // Head entry
    output logic                   cmd_credit  // One credit back to upstream
);

    import cnt_types_pkg::*;
    import cnt_msg_pkg::*;

    localparam int PTR_W = (`CNT_CMD_DEPTH > 1) ? $clog2(`CNT_CMD_DEPTH) : 1;

    load_cmd_t        mem [`CNT_CMD_DEPTH]; // Entry storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    credit_t          occ;                  // Entries held
    logic             full;
    logic             push;
    logic             pop;

    assign full    = (occ == credit_t'(`CNT_CMD_DEPTH));
    assign q_valid = (occ != '0);
    assign q_cmd   = mem[rd_ptr];

    // Overflow write without a credit is dropped
    assign push = cmd_valid && !full;
    assign pop  = q_pop && q_valid;

    assign cmd_credit = pop; // Same cycle as the pop

    // Entry write, no reset on payload
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end else begin
            if (push) begin
                // Wrap at depth, also for non power of two
                if (wr_ptr == PTR_W'(`CNT_CMD_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == PTR_W'(`CNT_CMD_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // Push and pop together leave occupancy alone
            case ({push, pop})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: cnt_msg_pkg.sv
// Message formats moving between upstream, the timer and downstream
// Load commands come in, expiry events go out
`default_nettype none

package cnt_msg_pkg;

    import cnt_types_pkg::*;

    // Upstream load request
    typedef struct packed {
        tag_t   tag;   // Returned unchanged in the event
        count_t start; // Ticks until expiry
    } load_cmd_t;

    // Downstream expiry report
    typedef struct packed {
        tag_t   tag;   // Tag of the expired command
        count_t start; // Start value it was loaded with
    } expiry_evt_t;

endpackage

`default_nettype wire

// File: cnt_types_pkg.sv
// Width typedefs shared by every timer block
// Import where a count, segment, tag or credit value is declared
`default_nettype none

`include "cnt_macros.svh"

package cnt_types_pkg;

    // Start value and running count
    typedef logic [`CNT_WIDTH-1:0] count_t;

    // Count split across whole segments
    typedef logic [`CNT_PAD_WIDTH-1:0] padded_t;

    typedef logic [`CNT_SEG_WIDTH-1:0] seg_t; // One down-count digit

    // Command identifier
    typedef logic [`CNT_TAG_WIDTH-1:0] tag_t;

    typedef logic [`CNT_CREDIT_WIDTH-1:0] credit_t; // Credit or occupancy count

endpackage

`default_nettype wire

// File: cnt_macros.svh
// Sizing constants for the segmented down-count timer
// Include wherever widths, depths or credit counts are needed
`ifndef CNT_MACROS_SVH
`define CNT_MACROS_SVH

// Start value width
`define CNT_WIDTH 16

// One counter segment
`define CNT_SEG_WIDTH 4

// Segments needed to cover the start value, rounded up
`define CNT_N_SEG ((`CNT_WIDTH + `CNT_SEG_WIDTH - 1) / `CNT_SEG_WIDTH)

`define CNT_PAD_WIDTH (`CNT_N_SEG * `CNT_SEG_WIDTH) // Start value padded to whole segments

`define CNT_TAG_WIDTH 4 // Command tag carried through to the event

// Command queue entries, also upstream credits after reset
`define CNT_CMD_DEPTH 4

`define CNT_EVT_CREDITS_INIT 2 // Downstream credits held after reset

// Wide enough for 0 to CNT_CMD_DEPTH
`define CNT_CREDIT_WIDTH 3

`endif
